/* source/motorPwmPkg.sv */
package motorPwmPkg;

    // every position, pulse length and lost value is this wide
    localparam int posW = 16;

    // three motor phases, A B C
    localparam int phaseCount = 3;

    // twelve commutation steps make one electrical sector
    localparam int stepCount = 12;
    localparam int stepW = 4;

    // decision taken by a phase generator at each period start
    typedef enum logic [1:0] {
        // generator is outside an active step
        skipIdle = 2'd0,
        // summed length too short, period stays low and the sum carries over
        skipMinLimit = 2'd1,
        // period emits a pulse
        skipNone = 2'd2
    } skipReasonE;

    // frame timer states
    typedef enum logic [1:0] {
        tmIdle = 2'd0,
        tmRun = 2'd1,
        tmReport = 2'd2
    } timerStateE;

endpackage

/* source/stepFrameTimer.sv */
`timescale 1ns/1ps

module stepFrameTimer
    import motorPwmPkg::*;
#(
    parameter int periodLen = 64
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            cmdValid,
    input  logic [posW-1:0] cmdLenA,
    input  logic [posW-1:0] cmdLenB,
    input  logic [posW-1:0] cmdLenC,
    input  logic [7:0]      cmdPeriods,
    input  logic            repReady,
    output logic            cmdReady,
    output logic            repValid,
    output logic [posW-1:0] lenA,
    output logic [posW-1:0] lenB,
    output logic [posW-1:0] lenC,
    output logic            periodStart,
    output logic            stepFirst,
    output logic            stepLast,
    output logic            stepActive,
    output logic [stepW-1:0] stepIndex
);

    localparam int cntW = (periodLen < 2) ? 1 : $clog2(periodLen);
    localparam logic [cntW-1:0] cycleLast = cntW'(periodLen - 1);
    localparam logic [stepW-1:0] stepLastIdx = stepW'(stepCount - 1);

    timerStateE state;
    logic [cntW-1:0] cycleCnt;
    logic [7:0] periodLeft;
    logic firstCycle;
    logic cmdTake;
    logic repTake;
    logic periodEnd;

    assign cmdReady = (state == tmIdle);
    assign repValid = (state == tmReport);
    assign cmdTake = cmdValid && cmdReady;
    assign repTake = repValid && repReady;

    // strobes are decoded from the counters while a step runs
    assign stepActive = (state == tmRun);
    assign periodStart = stepActive && (cycleCnt == '0);
    assign stepFirst = stepActive && firstCycle;
    assign periodEnd = stepActive && (cycleCnt == cycleLast);
    assign stepLast = periodEnd && (periodLeft == 8'd1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= tmIdle;
            cycleCnt <= '0;
            periodLeft <= 8'd0;
            firstCycle <= 1'b0;
            stepIndex <= '0;
        end else begin
            case (state)
                tmIdle: begin
                    if (cmdTake) begin
                        state <= tmRun;
                        firstCycle <= 1'b1;
                        cycleCnt <= '0;
                        // a zero period count still runs a single period
                        periodLeft <= (cmdPeriods == 8'd0) ? 8'd1 : cmdPeriods;
                    end
                end
                tmRun: begin
                    firstCycle <= 1'b0;
                    if (periodEnd) begin
                        cycleCnt <= '0;
                        periodLeft <= periodLeft - 8'd1;
                        if (stepLast) begin
                            state <= tmReport;
                        end
                    end else begin
                        cycleCnt <= cycleCnt + 1'b1;
                    end
                end
                tmReport: begin
                    // hold here until the lost values are taken
                    if (repTake) begin
                        state <= tmIdle;
                        if (stepIndex == stepLastIdx) begin
                            stepIndex <= '0;
                        end else begin
                            stepIndex <= stepIndex + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= tmIdle;
                end
            endcase
        end
    end

    // command lengths latched at the transfer and held for the whole step
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lenA <= '0;
            lenB <= '0;
            lenC <= '0;
        end else if (cmdTake) begin
            lenA <= cmdLenA;
            lenB <= cmdLenB;
            lenC <= cmdLenC;
        end
    end

endmodule

/* source/phasePwmGenerator.sv */
`timescale 1ns/1ps

module phasePwmGenerator
    import motorPwmPkg::*;
#(
    parameter int periodLen = 64,
    parameter int minPulse = 8
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            stepActive,
    input  logic            periodStart,
    input  logic            stepFirst,
    input  logic            stepLast,
    input  logic [posW-1:0] pulseLen,
    output logic            pwm,
    output logic [posW-1:0] lostPos
);

    localparam logic [posW-1:0] periodLenW = posW'(periodLen);
    localparam logic [posW-1:0] minPulseW = posW'(minPulse);

    skipReasonE skipReason;
    logic [posW-1:0] posSum;
    logic [posW-1:0] pulseClip;
    logic [posW-1:0] remain;
    logic [posW-1:0] pulseCnt;
    logic [posW-1:0] pulseNext;
    logic [posW-1:0] wantAcc;
    logic [posW-1:0] realAcc;

    // length carried from skipped periods joins this period's request
    assign posSum = remain + pulseLen;

    // a pulse never runs longer than one period
    assign pulseClip = (posSum > periodLenW) ? periodLenW : posSum;

    always_comb begin
        if (!stepActive) begin
            skipReason = skipIdle;
        end else if (posSum < minPulseW) begin
            skipReason = skipMinLimit;
        end else begin
            skipReason = skipNone;
        end
    end

    // the pulse counter is cut at the step end so the output is low while
    // the report waits
    always_comb begin
        if (stepLast) begin
            pulseNext = '0;
        end else if (periodStart && (skipReason == skipNone)) begin
            pulseNext = pulseClip;
        end else if (pulseCnt != '0) begin
            pulseNext = pulseCnt - 1'b1;
        end else begin
            pulseNext = '0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pulseCnt <= '0;
            pwm <= 1'b0;
        end else begin
            pulseCnt <= pulseNext;
            pwm <= (pulseNext != '0);
        end
    end

    // remainder of skipped periods
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            remain <= '0;
        end else if (stepLast) begin
            remain <= '0;
        end else if (periodStart) begin
            case (skipReason)
                skipMinLimit: begin
                    remain <= posSum;
                end
                skipNone: begin
                    remain <= '0;
                end
                default: begin
                    remain <= remain;
                end
            endcase
        end
    end

    // wanted high cycles, one request per period
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wantAcc <= '0;
        end else if (stepLast) begin
            wantAcc <= '0;
        end else if (stepFirst) begin
            wantAcc <= pulseLen;
        end else if (periodStart) begin
            wantAcc <= wantAcc + pulseLen;
        end
    end

    // high cycles actually driven
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            realAcc <= '0;
        end else if (stepLast) begin
            realAcc <= '0;
        end else if (pwm) begin
            realAcc <= realAcc + 1'b1;
        end
    end

    // the high cycle in the stepLast cycle itself is not yet in realAcc
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lostPos <= '0;
        end else if (stepLast) begin
            lostPos <= wantAcc - realAcc - posW'(pwm);
        end
    end

endmodule

/* source/gateDriveStage.sv */
`timescale 1ns/1ps

module gateDriveStage
    import motorPwmPkg::*;
#(
    parameter int deadCycles = 2
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [phaseCount-1:0] pwmBits,
    input  logic [stepW-1:0]      stepIndex,
    input  logic                  stepFirst,
    output logic [phaseCount-1:0] gateHigh,
    output logic [phaseCount-1:0] gateLow
);

    localparam int deadW = (deadCycles < 1) ? 1 : $clog2(deadCycles + 1);
    localparam logic [stepW-1:0] halfStart = stepW'(stepCount / 2);

    logic lowHalf;
    logic prevLowHalf;
    logic sideChange;
    logic [deadW-1:0] deadCnt;

    // steps 0 to 5 drive the high side, 6 to 11 the low side
    assign lowHalf = (stepIndex >= halfStart);
    assign sideChange = stepFirst && (lowHalf != prevLowHalf);

    // after reset the low side counts as last used, so the first
    // high-side step also starts with dead time
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            prevLowHalf <= 1'b1;
            deadCnt <= '0;
        end else begin
            if (stepFirst) begin
                prevLowHalf <= lowHalf;
            end
            if (sideChange) begin
                deadCnt <= deadW'(deadCycles);
            end else if (deadCnt != '0) begin
                deadCnt <= deadCnt - 1'b1;
            end
        end
    end

    // the dead counter masks the first pwm cycles of the new step
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            gateHigh <= '0;
            gateLow <= '0;
        end else if (sideChange || (deadCnt != '0)) begin
            gateHigh <= '0;
            gateLow <= '0;
        end else if (lowHalf) begin
            gateHigh <= '0;
            gateLow <= pwmBits;
        end else begin
            gateHigh <= pwmBits;
            gateLow <= '0;
        end
    end

endmodule

/* source/motorPwmTop.sv */
`timescale 1ns/1ps

module motorPwmTop
    import motorPwmPkg::*;
#(
    parameter int periodLen = 64,
    parameter int minPulse = 8,
    parameter int deadCycles = 2
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  cmdValid,
    input  logic [posW-1:0]       cmdLenA,
    input  logic [posW-1:0]       cmdLenB,
    input  logic [posW-1:0]       cmdLenC,
    input  logic [7:0]            cmdPeriods,
    input  logic                  repReady,
    output logic                  cmdReady,
    output logic                  repValid,
    output logic [posW-1:0]       repLostA,
    output logic [posW-1:0]       repLostB,
    output logic [posW-1:0]       repLostC,
    output logic [phaseCount-1:0] gateHigh,
    output logic [phaseCount-1:0] gateLow
);

    logic [posW-1:0] lenA;
    logic [posW-1:0] lenB;
    logic [posW-1:0] lenC;
    logic periodStart;
    logic stepFirst;
    logic stepLast;
    logic stepActive;
    logic [stepW-1:0] stepIndex;
    logic [posW-1:0] phaseLen [phaseCount];
    logic [posW-1:0] phaseLost [phaseCount];
    logic [phaseCount-1:0] pwmBits;

    stepFrameTimer #(
        .periodLen(periodLen)
    ) stepFrameTimer_i (
        .clk(clk),
        .rstN(rstN),
        .cmdValid(cmdValid),
        .cmdLenA(cmdLenA),
        .cmdLenB(cmdLenB),
        .cmdLenC(cmdLenC),
        .cmdPeriods(cmdPeriods),
        .repReady(repReady),
        .cmdReady(cmdReady),
        .repValid(repValid),
        .lenA(lenA),
        .lenB(lenB),
        .lenC(lenC),
        .periodStart(periodStart),
        .stepFirst(stepFirst),
        .stepLast(stepLast),
        .stepActive(stepActive),
        .stepIndex(stepIndex)
    );

    // phase order A B C follows the loop index
    assign phaseLen[0] = lenA;
    assign phaseLen[1] = lenB;
    assign phaseLen[2] = lenC;

    for (genvar p = 0; p < phaseCount; p++) begin : genPhase
        phasePwmGenerator #(
            .periodLen(periodLen),
            .minPulse(minPulse)
        ) phasePwmGenerator_i (
            .clk(clk),
            .rstN(rstN),
            .stepActive(stepActive),
            .periodStart(periodStart),
            .stepFirst(stepFirst),
            .stepLast(stepLast),
            .pulseLen(phaseLen[p]),
            .pwm(pwmBits[p]),
            .lostPos(phaseLost[p])
        );
    end

    assign repLostA = phaseLost[0];
    assign repLostB = phaseLost[1];
    assign repLostC = phaseLost[2];

    gateDriveStage #(
        .deadCycles(deadCycles)
    ) gateDriveStage_i (
        .clk(clk),
        .rstN(rstN),
        .pwmBits(pwmBits),
        .stepIndex(stepIndex),
        .stepFirst(stepFirst),
        .gateHigh(gateHigh),
        .gateLow(gateLow)
    );

endmodule

/* sim/motorPwmTb.sv */
`timescale 1ns/1ps

module motorPwmTb
    import motorPwmPkg::*;
();

    localparam int periodLen = 64;
    localparam int minPulse = 8;
    localparam int deadCycles = 2;
    localparam int clkPeriod = 8;
    localparam int resetCycles = 10;
    localparam logic [1:0] halfNone = 2'd0;
    localparam logic [1:0] halfHigh = 2'd1;
    localparam logic [1:0] halfLow = 2'd2;

    logic clk;
    logic rstN;
    logic cmdValid;
    logic [posW-1:0] cmdLenA;
    logic [posW-1:0] cmdLenB;
    logic [posW-1:0] cmdLenC;
    logic [7:0] cmdPeriods;
    logic repReady;
    logic cmdReady;
    logic repValid;
    logic [posW-1:0] repLostA;
    logic [posW-1:0] repLostB;
    logic [posW-1:0] repLostC;
    logic [phaseCount-1:0] gateHigh;
    logic [phaseCount-1:0] gateLow;

    // cases are stored flat, three entries per case for lengths and lost values
    int caseLen[$];
    int caseLost[$];
    int casePeriods[$];
    int hiCnt [phaseCount];
    int loCnt [phaseCount];
    int errCount;
    int passCount;
    int failCount;
    logic [31:0] rngState;
    longint watchCycles;
    bit watchArmed;

    motorPwmTop #(
        .periodLen(periodLen),
        .minPulse(minPulse),
        .deadCycles(deadCycles)
    ) motorPwmTop_i (
        .clk(clk),
        .rstN(rstN),
        .cmdValid(cmdValid),
        .cmdLenA(cmdLenA),
        .cmdLenB(cmdLenB),
        .cmdLenC(cmdLenC),
        .cmdPeriods(cmdPeriods),
        .repReady(repReady),
        .cmdReady(cmdReady),
        .repValid(repValid),
        .repLostA(repLostA),
        .repLostB(repLostB),
        .repLostC(repLostC),
        .gateHigh(gateHigh),
        .gateLow(gateLow)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    // gate high cycles are counted in the middle of each clock period
    always @(negedge clk) begin
        if (rstN) begin
            for (int p = 0; p < phaseCount; p++) begin
                hiCnt[p] += int'(gateHigh[p]);
                loCnt[p] += int'(gateLow[p]);
            end
        end
    end

    initial begin
        wait (watchArmed);
        #(watchCycles * clkPeriod);
        $display("timeout: the DUT stopped answering before all cases were done");
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshiftNext(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic string phaseTag(input int p);
        return (p == 0) ? "A" : ((p == 1) ? "B" : "C");
    endfunction

    // bit 0 says the high bus carried pulses, bit 1 the low bus
    function automatic logic [1:0] halfOf(input logic hiAny, input logic loAny);
        return {loAny, hiAny};
    endfunction

    task automatic checkFlag(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("CHECK FAILED t=%0t %s expected %0b actual %0b", $time, name, expVal, actVal);
            errCount++;
        end
    endtask

    task automatic checkLost(input string name, input logic [posW-1:0] expVal,
                             input logic [posW-1:0] actVal);
        if (actVal !== expVal) begin
            $display("CHECK FAILED t=%0t %s expected %0d actual %0d", $time, name, expVal, actVal);
            errCount++;
        end
    endtask

    task automatic checkGateCount(input string name, input int expVal, input int actVal);
        if (actVal != expVal) begin
            $display("CHECK FAILED t=%0t %s expected %0d actual %0d", $time, name, expVal, actVal);
            errCount++;
        end
    endtask

    task automatic checkHalf(input string name, input logic [1:0] expVal,
                             input logic [1:0] actVal);
        if (actVal !== expVal) begin
            $display("CHECK FAILED t=%0t %s expected %0d actual %0d", $time, name, expVal, actVal);
            errCount++;
        end
    endtask

    task automatic reportTest(input string name);
        if (errCount == 0) begin
            passCount++;
            $display("%s: pass", name);
        end else begin
            failCount++;
            $display("%s: %0d check(s) failed", name, errCount);
        end
    endtask

    // high cycles of one phase in one step, and the length of its first pulse
    task automatic modelPhase(input int len, input int periods, output int highCycles,
                              output int firstPulse);
        int remain;
        int sum;
        int pulse;
        remain = 0;
        highCycles = 0;
        firstPulse = 0;
        for (int i = 0; i < periods; i++) begin
            sum = remain + len;
            if (sum < minPulse) begin
                remain = sum;
                pulse = 0;
            end else begin
                remain = 0;
                pulse = (sum > periodLen) ? periodLen : sum;
            end
            // the step end cuts the final period's pulse one cycle short of the full period
            if ((i == periods - 1) && (pulse > periodLen - 1)) begin
                pulse = periodLen - 1;
            end
            highCycles += pulse;
            if (i == 0) begin
                firstPulse = pulse;
            end
        end
    endtask

    task automatic runCase(input int idx);
        int step;
        int hold;
        int first;
        int modelSum;
        int hiSum;
        int loSum;
        int model [phaseCount];
        int startHi [phaseCount];
        int startLo [phaseCount];
        logic deadStep;
        logic [1:0] expHalf;
        logic [posW-1:0] lostSeen [phaseCount];
        logic [posW-1:0] lostNow [phaseCount];
        errCount = 0;
        step = idx % stepCount;
        deadStep = (step == 0) || (step == stepCount / 2);
        startHi = hiCnt;
        startLo = loCnt;
        cmdLenA = posW'(caseLen[3 * idx]);
        cmdLenB = posW'(caseLen[3 * idx + 1]);
        cmdLenC = posW'(caseLen[3 * idx + 2]);
        cmdPeriods = 8'(casePeriods[idx]);
        cmdValid = 1'b1;
        while (!cmdReady) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        cmdValid = 1'b0;
        while (!repValid) begin
            @(posedge clk);
            #1;
        end
        lostSeen[0] = repLostA;
        lostSeen[1] = repLostB;
        lostSeen[2] = repLostC;
        rngState = xorshiftNext(rngState);
        hold = int'(rngState % 32'd8);
        // offer the same command again while the report is held back
        cmdValid = 1'b1;
        for (int h = 0; h < hold; h++) begin
            @(posedge clk);
            #1;
            checkFlag("cmdReady", 1'b0, cmdReady);
            checkFlag("repValid", 1'b1, repValid);
            checkHalf("gates in stall", halfNone, halfOf(|gateHigh, |gateLow));
        end
        lostNow[0] = repLostA;
        lostNow[1] = repLostB;
        lostNow[2] = repLostC;
        for (int p = 0; p < phaseCount; p++) begin
            checkLost($sformatf("repLost%s", phaseTag(p)), posW'(caseLost[3 * idx + p]),
                      lostNow[p]);
            checkLost($sformatf("repLost%s held", phaseTag(p)), lostSeen[p], lostNow[p]);
        end
        cmdValid = 1'b0;
        repReady = 1'b1;
        @(posedge clk);
        #1;
        repReady = 1'b0;
        modelSum = 0;
        hiSum = 0;
        loSum = 0;
        for (int p = 0; p < phaseCount; p++) begin
            modelPhase(caseLen[3 * idx + p], casePeriods[idx], model[p], first);
            if (deadStep) begin
                model[p] -= (first < deadCycles) ? first : deadCycles;
            end
            hiSum += hiCnt[p] - startHi[p];
            loSum += loCnt[p] - startLo[p];
            modelSum += model[p];
            if (step < stepCount / 2) begin
                checkGateCount($sformatf("gateHigh[%0d] count", p), model[p],
                               hiCnt[p] - startHi[p]);
            end else begin
                checkGateCount($sformatf("gateLow[%0d] count", p), model[p],
                               loCnt[p] - startLo[p]);
            end
        end
        expHalf = (modelSum == 0) ? halfNone : ((step < stepCount / 2) ? halfHigh : halfLow);
        checkHalf("gate side", expHalf, halfOf(hiSum != 0, loSum != 0));
        reportTest($sformatf("case %0d step %0d", idx, step));
    endtask

    initial begin
        int fd;
        int n;
        int a;
        int b;
        int c;
        int per;
        int la;
        int lb;
        int lc;
        longint totalCycles;
        string line;
        rstN = 1'b0;
        cmdValid = 1'b0;
        cmdLenA = '0;
        cmdLenB = '0;
        cmdLenC = '0;
        cmdPeriods = 8'd0;
        repReady = 1'b0;
        rngState = 32'd80;
        passCount = 0;
        failCount = 0;
        errCount = 0;
        totalCycles = 0;
        fd = $fopen("sim/motorPwmCases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file sim/motorPwmCases.txt");
            failCount++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if ((line.len() > 0) && (line.getc(0) != "#")) begin
                    n = $sscanf(line, "%d %d %d %d %d %d %d", a, b, c, per, la, lb, lc);
                    if (n == 7) begin
                        caseLen.push_back(a);
                        caseLen.push_back(b);
                        caseLen.push_back(c);
                        casePeriods.push_back(per);
                        caseLost.push_back(la);
                        caseLost.push_back(lb);
                        caseLost.push_back(lc);
                        totalCycles += longint'(per * periodLen);
                    end
                end
            end
            $fclose(fd);
            if (casePeriods.size() == 0) begin
                $display("the case file holds no usable case lines");
                failCount++;
            end
        end
        watchCycles = totalCycles + longint'(20 * casePeriods.size()) + longint'(resetCycles);
        watchArmed = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
        @(posedge clk);
        #1;
        checkFlag("cmdReady", 1'b1, cmdReady);
        checkFlag("repValid", 1'b0, repValid);
        checkHalf("gates after reset", halfNone, halfOf(|gateHigh, |gateLow));
        reportTest("reset");
        for (int i = 0; i < casePeriods.size(); i++) begin
            runCase(i);
        end
        $display("summary: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* sim/motorPwmCases.txt */
# one step command per line, decimal, step index follows the line order from 0
# lenA lenB lenC periods lostA lostB lostC
20 30 40 2 0 0 0
3 5 7 9 0 5 7
64 100 40000 2 1 73 14337
8 63 0 3 0 0 0
10 2 65 1 0 2 2
1 4 9 16 0 0 0
32 48 16 4 0 0 0
6 6 6 5 6 6 6
0 64 33 1 0 1 0
7 50 3 6 0 0 0
200 12 5 3 409 0 5
16 24 8 200 0 0 0

/* project.f */
source/motorPwmPkg.sv
source/stepFrameTimer.sv
source/phasePwmGenerator.sv
source/gateDriveStage.sv
source/motorPwmTop.sv
sim/motorPwmTb.sv

/* runSim.sh */
#!/bin/sh
# build with Verilator from the project root, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log \
    && verilator --binary -j 0 --top-module motorPwmTb -f project.f -o motorPwmSim \
    && ./obj_dir/motorPwmSim | tee sim.log \
    || { echo "build or run failed"; exit 1; }
grep -q "STATUS: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
